// ==== Bender.yml ====
package:
  name: lbls_bank

sources:
  # shared package first, then leaf modules, then the top level
  - design/lbls_pkg.sv
  - design/count_ones.sv
  - design/iserdes_counter.sv
  - design/iserdes_scaler_array.sv
  - design/lbls_channel.sv
  - design/lbls_bank.sv

  - target: test
    files:
      - verif/lbls_bank_tb.sv

// ==== design/count_ones.sv ====
// ####################
// count_ones
// registered population count of one word
// ####################

module count_ones
	import lbls_pkg::*;
(
	input  logic         clock,
	input  serdes_word_t data_in,
	output ones_count_t  count_out
);

	// one cycle of latency
	always_ff @(posedge clock) begin
		count_out <= ones_count_t'($countones(data_in));
	end

	// a word never holds more ones than it has bits
	count_in_range: assert property (
		@(posedge clock) !$isunknown(count_out) |-> count_out <= WORD_BITS
	) else $error("count_ones result %0d above word width", count_out);

endmodule

// ==== design/iserdes_counter.sv ====
// ####################
// iserdes_counter
// free-running count of high samples for one
// channel, with synchronous clear
// ####################

module iserdes_counter
	import lbls_pkg::*;
#(
	parameter int COUNTER_WIDTH = 32
) (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     clear,
	input  serdes_word_t             word,
	output logic [COUNTER_WIDTH-1:0] count
);

	// ones in the current word, widened to the counter
	logic [COUNTER_WIDTH-1:0] word_ones;

	always_comb begin
		word_ones = COUNTER_WIDTH'($countones(word));
	end

	// wraps on overflow
	// clear drops the word of the same edge
	always_ff @(posedge clock) begin
		if (reset || clear) begin
			count <= '0;
		end else begin
			count <= count + word_ones;
		end
	end

endmodule

// ==== design/iserdes_scaler_array.sv ====
// ####################
// iserdes_scaler_array
// saturating rate scalers for all channels
// over one shared accumulation period
// ####################

module iserdes_scaler_array
	import lbls_pkg::*;
#(
	parameter int SCALER_WIDTH       = 16,
	parameter int ACCUMULATE_PERIODS = 2500000
) (
	input  logic                                      clock,
	input  logic                                      reset,
	input  serdes_word_t [NUM_CHANNELS-1:0]           words,
	output logic [NUM_CHANNELS-1:0][SCALER_WIDTH-1:0] rates
);

	// period counter width, at least one bit
	localparam int PERIOD_BITS =
		(ACCUMULATE_PERIODS > 1) ? $clog2(ACCUMULATE_PERIODS) : 1;
	// accumulator holds a full period of all-ones words
	localparam int ACC_WIDTH = $clog2(ACCUMULATE_PERIODS * WORD_BITS + 1);
	localparam logic [PERIOD_BITS-1:0] LAST_PERIOD = PERIOD_BITS'(ACCUMULATE_PERIODS - 1);

	logic [PERIOD_BITS-1:0] period_count;
	logic                   period_end;
	logic [ACC_WIDTH-1:0]   acc [NUM_CHANNELS];
	// accumulator plus the word of this edge
	logic [ACC_WIDTH-1:0]   sum [NUM_CHANNELS];

	assign period_end = (period_count == LAST_PERIOD);

	always_comb begin
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			sum[ch] = acc[ch] + ACC_WIDTH'($countones(words[ch]));
		end
	end

	// shared period counter
	always_ff @(posedge clock) begin
		if (reset || period_end) begin
			period_count <= '0;
		end else begin
			period_count <= period_count + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
				acc[ch]   <= '0;
				rates[ch] <= '0;
			end
		end else if (period_end) begin
			for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
				acc[ch] <= '0;
				// anything above the scaler range pins at all ones
				if ((sum[ch] >> SCALER_WIDTH) != '0) begin
					rates[ch] <= '1;
				end else begin
					rates[ch] <= SCALER_WIDTH'(sum[ch]);
				end
			end
		end else begin
			for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
				acc[ch] <= sum[ch];
			end
		end
	end

	// the counter must wrap at the period, never run past it
	period_in_range: assert property (
		@(posedge clock) disable iff (reset) period_count < ACCUMULATE_PERIODS
	) else $error("scaler period counter %0d out of range", period_count);

endmodule

// ==== design/lbls_bank.sv ====
// ####################
// lbls_bank
// twelve-channel light sensor readout with
// counters, rate scalers, time over threshold
// and a global any flag
// ####################

module lbls_bank
	import lbls_pkg::*;
#(
	parameter int COUNTER_WIDTH      = 32,
	parameter int SCALER_WIDTH       = 16,
	parameter int ACCUMULATE_PERIODS = 2500000
) (
	input  logic                                       clock,
	input  logic                                       reset,
	input  channel_mask_t                              hit_mask,
	input  channel_mask_t                              inversion_mask,
	input  logic                                       gate,
	input  logic                                       clear_channel_counters,
	input  logic                                       trigger_active,
	input  serdes_word_t [NUM_CHANNELS-1:0]            win,
	output logic [NUM_CHANNELS-1:0][SCALER_WIDTH-1:0]  sc,
	output tot_t [NUM_CHANNELS-1:0]                    tot,
	output logic [NUM_CHANNELS-1:0][COUNTER_WIDTH-1:0] c,
	output logic                                       any
);

	// words after the per-channel inversion
	serdes_word_t [NUM_CHANNELS-1:0] word;
	// registered hit bit of every channel
	channel_mask_t                   hit;
	// no enabled channel has a nonzero word this cycle
	logic                            masked_idle;

	for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : channel_gen
		// sensors that idle high get flipped here
		assign word[ch] = win[ch] ^ {WORD_BITS{inversion_mask[ch]}};

		// counts every sample, mask and gate do not apply
		iserdes_counter #(
			.COUNTER_WIDTH (COUNTER_WIDTH)
		) counter_inst (
			.clock (clock),
			.reset (reset),
			.clear (clear_channel_counters),
			.word  (word[ch]),
			.count (c[ch])
		);

		lbls_channel channel_inst (
			.clock          (clock),
			.reset          (reset),
			.gate           (gate),
			.trigger_active (trigger_active),
			.hit_enable     (hit_mask[ch]),
			.word           (word[ch]),
			.hit            (hit[ch]),
			.tot            (tot[ch])
		);
	end

	// rate scalers see the inverted words, unmasked
	iserdes_scaler_array #(
		.SCALER_WIDTH       (SCALER_WIDTH),
		.ACCUMULATE_PERIODS (ACCUMULATE_PERIODS)
	) scaler_array_inst (
		.clock (clock),
		.reset (reset),
		.words (word),
		.rates (sc)
	);

	// any lands two cycles after the word
	always_ff @(posedge clock) begin
		if (reset) begin
			any <= 1'b0;
		end else begin
			any <= |hit;
		end
	end

	// same masking as inside the channels, for the check below
	always_comb begin
		masked_idle = 1'b1;
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			if (hit_mask[ch] && gate && (word[ch] != '0)) begin
				masked_idle = 1'b0;
			end
		end
	end

	// nothing enabled and gated means no any flag two cycles on
	any_needs_hit: assert property (
		@(posedge clock) disable iff (reset) masked_idle |=> ##1 !any
	) else $error("any raised without a masked, gated hit");

endmodule

// ==== design/lbls_channel.sv ====
// ####################
// lbls_channel
// hit masking, word buffer, hit flag and
// time over threshold for one channel
// ####################

module lbls_channel
	import lbls_pkg::*;
(
	input  logic         clock,
	input  logic         reset,
	input  logic         gate,
	input  logic         trigger_active,
	input  logic         hit_enable,
	input  serdes_word_t word,
	output logic         hit,
	output tot_t         tot
);

	serdes_word_t masked_word;
	serdes_word_t word_buffered;
	ones_count_t  word_ones;
	// running sum while the trigger is active
	tot_t         tot_running;
	// sum of the last finished trigger window
	tot_t         tot_previous;

	// word is already inverted upstream
	// masked channels and a closed gate give all zeros
	assign masked_word = word & {WORD_BITS{hit_enable & gate}};

	// buffer and hit both land one cycle after the word
	always_ff @(posedge clock) begin
		if (reset) begin
			word_buffered <= '0;
			hit           <= 1'b0;
		end else begin
			word_buffered <= masked_word;
			hit           <= |masked_word;
		end
	end

	// ones of the buffered word, another cycle later
	count_ones count_ones_inst (
		.clock     (clock),
		.data_in   (word_buffered),
		.count_out (word_ones)
	);

	// accumulate during the trigger
	// hand over and restart on every idle edge
	always_ff @(posedge clock) begin
		if (reset) begin
			tot_running  <= '0;
			tot_previous <= '0;
		end else if (trigger_active) begin
			tot_running <= tot_running + tot_t'(word_ones);
		end else begin
			tot_previous <= tot_running;
			tot_running  <= '0;
		end
	end

	assign tot = tot_previous;

	// closed gate must suppress the hit of the next cycle
	hit_follows_gate: assert property (
		@(posedge clock) disable iff (reset) !gate |=> !hit
	) else $error("hit raised after a cycle with gate low");

endmodule

// ==== design/lbls_pkg.sv ====
// ####################
// lbls package
// channel count, word width and the
// shared types of the light sensor bank
// ####################

package lbls_pkg;

	// channels in one bank
	localparam int NUM_CHANNELS = 12;

	// discriminator samples per deserialized word
	localparam int WORD_BITS = 8;

	// one deserialized word, oldest sample in no particular bit
	typedef logic [WORD_BITS-1:0] serdes_word_t;

	// one bit per channel
	// hit mask, inversion mask and the hit vector
	typedef logic [NUM_CHANNELS-1:0] channel_mask_t;

	// high samples in one word, 0 to 8
	typedef logic [3:0] ones_count_t;

	// time over threshold in samples, wraps at 256
	typedef logic [7:0] tot_t;

endpackage

// ==== sim.f ====
design/lbls_pkg.sv
design/count_ones.sv
design/iserdes_counter.sv
design/iserdes_scaler_array.sv
design/lbls_channel.sv
design/lbls_bank.sv
verif/lbls_bank_tb.sv

// ==== verif/lbls_bank_tb.sv ====
// ####################
// lbls_bank testbench
// phase table stimulus with a cycle model
// of every output of the bank
// ####################

module lbls_bank_tb
	import lbls_pkg::*;
();

	localparam int COUNTER_WIDTH      = 32;
	localparam int SCALER_WIDTH       = 6;
	localparam int ACCUMULATE_PERIODS = 16;
	localparam int RATE_MAX           = 2 ** SCALER_WIDTH - 1;
	localparam int RESET_CYCLES       = 8;
	localparam int NUM_PHASES         = 9;

	// word sources of a phase
	localparam int MODE_FIXED  = 0;
	localparam int MODE_RANDOM = 1;
	// and of two draws gives about two ones per word
	localparam int MODE_SPARSE = 2;

	typedef struct {
		int            cycles;
		channel_mask_t hit_mask;
		channel_mask_t inversion_mask;
		logic          gate;
		int            trigger_high;
		int            trigger_period;
		int            clear_at;
		int            word_mode;
		serdes_word_t  fixed_word;
	} phase_t;

	logic                                       clock;
	logic                                       reset;
	channel_mask_t                              hit_mask;
	channel_mask_t                              inversion_mask;
	logic                                       gate;
	logic                                       clear_channel_counters;
	logic                                       trigger_active;
	serdes_word_t [NUM_CHANNELS-1:0]            win;
	logic [NUM_CHANNELS-1:0][SCALER_WIDTH-1:0]  sc;
	tot_t [NUM_CHANNELS-1:0]                    tot;
	logic [NUM_CHANNELS-1:0][COUNTER_WIDTH-1:0] c;
	logic                                       any;

	phase_t      phases [NUM_PHASES];
	logic [31:0] rng_state;
	int          cycle_count;
	int          cycle_limit;

	// model state with one entry per channel
	logic [COUNTER_WIDTH-1:0] exp_c [NUM_CHANNELS];
	serdes_word_t             exp_buf [NUM_CHANNELS];
	logic                     exp_hit [NUM_CHANNELS];
	ones_count_t              exp_ones [NUM_CHANNELS];
	tot_t                     exp_run [NUM_CHANNELS];
	tot_t                     exp_tot [NUM_CHANNELS];
	int                       exp_acc [NUM_CHANNELS];
	logic [SCALER_WIDTH-1:0]  exp_sc [NUM_CHANNELS];
	logic                     exp_any;
	int                       exp_period;

	// things the run has to reach at least once
	logic saw_any;
	logic saw_tot;
	logic saw_saturated;
	logic saw_rate;

	lbls_bank #(
		.COUNTER_WIDTH      (COUNTER_WIDTH),
		.SCALER_WIDTH       (SCALER_WIDTH),
		.ACCUMULATE_PERIODS (ACCUMULATE_PERIODS)
	) lbls_bank_inst (
		.clock                  (clock),
		.reset                  (reset),
		.hit_mask               (hit_mask),
		.inversion_mask         (inversion_mask),
		.gate                   (gate),
		.clear_channel_counters (clear_channel_counters),
		.trigger_active         (trigger_active),
		.win                    (win),
		.sc                     (sc),
		.tot                    (tot),
		.c                      (c),
		.any                    (any)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// run limit counts reset cycles too
	initial begin
		cycle_count = 0;
	end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("timeout after %0d cycles, the stimulus never completed", cycle_count);
			$display("tests failed");
			$fatal(1);
		end
	end

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic draw_word(output serdes_word_t w);
		rng_state = xorshift32(rng_state);
		w = rng_state[WORD_BITS-1:0];
	endtask

	// high samples in a word counted bit by bit
	function automatic int ones_in(serdes_word_t w);
		int n;
		n = 0;
		for (int b = 0; b < WORD_BITS; b++) begin
			n = n + int'(w[b]);
		end
		return n;
	endfunction

	task automatic set_phase(int idx, int cycles, channel_mask_t hm, channel_mask_t inv,
		logic g, int trig_high, int trig_period, int clear_at, int mode, serdes_word_t fixed);
		phases[idx].cycles         = cycles;
		phases[idx].hit_mask       = hm;
		phases[idx].inversion_mask = inv;
		phases[idx].gate           = g;
		phases[idx].trigger_high   = trig_high;
		phases[idx].trigger_period = trig_period;
		phases[idx].clear_at       = clear_at;
		phases[idx].word_mode      = mode;
		phases[idx].fixed_word     = fixed;
	endtask

	task automatic build_table();
		// idle words straight after reset
		set_phase(0, 10, 12'hfff, 12'h000, 1'b1, 0, 0, -1, MODE_FIXED, 8'h00);
		// gate closed while counters still run and clear mid phase
		set_phase(1, 20, 12'hfff, 12'h0f0, 1'b0, 6, 10, 12, MODE_RANDOM, 8'h00);
		// all ones but no channel enabled
		set_phase(2, 12, 12'h000, 12'h000, 1'b1, 0, 0, 5, MODE_FIXED, 8'hff);
		// partial hit mask so any follows the hits
		set_phase(3, 20, 12'h5a3, 12'h000, 1'b1, 0, 0, -1, MODE_SPARSE, 8'h00);
		// short trigger windows on partly inverted channels
		set_phase(4, 56, 12'hfff, 12'h3c3, 1'b1, 9, 14, -1, MODE_RANDOM, 8'h00);
		// one long window whose sum wraps past 255
		set_phase(5, 48, 12'hfff, 12'h00f, 1'b1, 40, 48, -1, MODE_FIXED, 8'hff);
		// scaler windows below saturation
		set_phase(6, 48, 12'hfff, 12'h000, 1'b1, 0, 0, -1, MODE_SPARSE, 8'h00);
		// half the channels saturate and the other half read zero
		set_phase(7, 40, 12'hfff, 12'haaa, 1'b1, 0, 0, 20, MODE_FIXED, 8'hff);
		// gate closed on all ones words
		set_phase(8, 12, 12'hfff, 12'h000, 1'b0, 0, 0, -1, MODE_FIXED, 8'hff);
	endtask

	task automatic check_count(string name, logic [COUNTER_WIDTH-1:0] got,
		logic [COUNTER_WIDTH-1:0] expected);
		if (got !== expected) begin
			$display("error %s got %h expected %h", name, got, expected);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic check_rate(string name, logic [SCALER_WIDTH-1:0] got,
		logic [SCALER_WIDTH-1:0] expected);
		if (got !== expected) begin
			$display("error %s got %h expected %h", name, got, expected);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic check_tot(string name, tot_t got, tot_t expected);
		if (got !== expected) begin
			$display("error %s got %h expected %h", name, got, expected);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic check_flag(string name, logic got, logic expected);
		if (got !== expected) begin
			$display("error %s got %h expected %h", name, got, expected);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	// outputs settle after the rising edge and are sampled on the falling one
	task automatic check_outputs();
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			check_count($sformatf("c[%0d]", ch), c[ch], exp_c[ch]);
			check_rate($sformatf("sc[%0d]", ch), sc[ch], exp_sc[ch]);
			check_tot($sformatf("tot[%0d]", ch), tot[ch], exp_tot[ch]);
		end
		check_flag("any", any, exp_any);
	endtask

	// inputs for cycle k of phase p
	task automatic apply_inputs(int p, int k);
		serdes_word_t a;
		serdes_word_t b;
		reset                  = 1'b0;
		hit_mask               = phases[p].hit_mask;
		inversion_mask         = phases[p].inversion_mask;
		gate                   = phases[p].gate;
		clear_channel_counters = (k == phases[p].clear_at);
		trigger_active         = (phases[p].trigger_period > 0) &&
			((k % phases[p].trigger_period) < phases[p].trigger_high);
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			if (phases[p].word_mode == MODE_RANDOM) begin
				draw_word(a);
				win[ch] = a;
			end else if (phases[p].word_mode == MODE_SPARSE) begin
				draw_word(a);
				draw_word(b);
				win[ch] = a & b;
			end else begin
				win[ch] = phases[p].fixed_word;
			end
		end
	endtask

	// state after the next rising edge
	// old values are read before they change
	task automatic predict_edge();
		serdes_word_t w;
		int           sum;
		logic         period_end;
		logic         any_next;
		period_end = (exp_period == ACCUMULATE_PERIODS - 1);
		any_next   = 1'b0;
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			any_next = any_next | exp_hit[ch];
		end
		exp_any = any_next;
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			// idle-high sensors read flipped
			w = inversion_mask[ch] ? ~win[ch] : win[ch];
			// counter ignores mask and gate
			if (clear_channel_counters) begin
				exp_c[ch] = '0;
			end else begin
				exp_c[ch] = exp_c[ch] + COUNTER_WIDTH'(ones_in(w));
			end
			// tot uses the ones count of two words back
			if (trigger_active) begin
				exp_run[ch] = exp_run[ch] + tot_t'(exp_ones[ch]);
			end else begin
				exp_tot[ch] = exp_run[ch];
				exp_run[ch] = '0;
			end
			exp_ones[ch] = ones_count_t'(ones_in(exp_buf[ch]));
			exp_buf[ch]  = (hit_mask[ch] && gate) ? w : '0;
			exp_hit[ch]  = (exp_buf[ch] != '0);
			// scaler sum includes the word of this edge
			sum = exp_acc[ch] + ones_in(w);
			if (period_end) begin
				exp_acc[ch] = 0;
				exp_sc[ch]  = SCALER_WIDTH'((sum > RATE_MAX) ? RATE_MAX : sum);
				if (sum > RATE_MAX) begin
					saw_saturated = 1'b1;
				end else if (sum > 0) begin
					saw_rate = 1'b1;
				end
			end else begin
				exp_acc[ch] = sum;
			end
			if (exp_tot[ch] != '0) begin
				saw_tot = 1'b1;
			end
		end
		exp_period = period_end ? 0 : exp_period + 1;
		if (exp_any) begin
			saw_any = 1'b1;
		end
	endtask

	initial begin
		int   total;
		logic missing;
		reset                  = 1'b1;
		hit_mask               = '0;
		inversion_mask         = '0;
		gate                   = 1'b0;
		clear_channel_counters = 1'b0;
		trigger_active         = 1'b0;
		win                    = '0;
		rng_state              = 32'd48;
		saw_any                = 1'b0;
		saw_tot                = 1'b0;
		saw_saturated          = 1'b0;
		saw_rate               = 1'b0;
		missing                = 1'b0;
		exp_any                = 1'b0;
		exp_period             = 0;
		// reset value of every register
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			exp_c[ch]    = '0;
			exp_buf[ch]  = '0;
			exp_hit[ch]  = 1'b0;
			exp_ones[ch] = '0;
			exp_run[ch]  = '0;
			exp_tot[ch]  = '0;
			exp_acc[ch]  = 0;
			exp_sc[ch]   = '0;
		end
		build_table();
		total = 0;
		for (int p = 0; p < NUM_PHASES; p++) begin
			total = total + phases[p].cycles;
		end
		cycle_limit = total + 100;

		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		for (int p = 0; p < NUM_PHASES; p++) begin
			for (int k = 0; k < phases[p].cycles; k++) begin
				check_outputs();
				apply_inputs(p, k);
				predict_edge();
				@(negedge clock);
			end
		end
		check_outputs();

		// stimulus must have exercised each path
		if (!saw_any) begin
			$display("the any flag never rose during the run");
			missing = 1'b1;
		end
		if (!saw_tot) begin
			$display("no time over threshold value was ever presented");
			missing = 1'b1;
		end
		if (!saw_saturated || !saw_rate) begin
			$display("the scalers did not show both saturated and plain windows");
			missing = 1'b1;
		end
		if (missing) begin
			$display("tests failed");
			$fatal(1);
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule
